//--- common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and address width.
`define CORE_DATA_W 16

// Register select width and register count.
`define CORE_REG_SEL_W 4
`define CORE_REG_COUNT 16

// Data memory depth in 16-bit words.
`define CORE_MEM_WORDS 256

// Bubble filler values.
`define CORE_NOP_FILL 16'hffff
`define CORE_NOP_INSTR 16'h0800
`define CORE_NOP_SEL 4'hf

`endif

//--- common/isa_pkg.sv
package isa_pkg;

    // Upper five bits of the instruction word.
    typedef enum logic [4:0] {
        HALT = 5'b00000,
        NOP  = 5'b00001,
        JAL  = 5'b00110,
        ST   = 5'b10000,
        LD   = 5'b10001
    } opcode_e;

    // Where the register write value comes from.
    typedef enum logic [1:0] {
        ALU  = 2'd0,
        MEM  = 2'd1,
        LINK = 2'd2
    } wb_src_e;

    // Processor status, sticky until reset.
    typedef enum logic [1:0] {
        RUN    = 2'd0,
        HALTED = 2'd1,
        FAULT  = 2'd2
    } core_status_e;

endpackage

//--- common/pipe_pkg.sv
`include "core_defines.svh"

package pipe_pkg;

    // Execute to memory bundle.
    typedef struct packed {
        logic [`CORE_DATA_W-1:0]    pc;
        logic [`CORE_DATA_W-1:0]    instruction;
        logic [`CORE_DATA_W-1:0]    alu_out;
        logic [`CORE_DATA_W-1:0]    store_data;
        logic                       mem_read;
        logic                       mem_write;
        logic                       mem_to_reg;
        logic                       link;
        logic                       reg_write;
        logic                       halt;
        logic [`CORE_REG_SEL_W-1:0] write_sel;
        logic                       instr_align_err;
    } ex_mem_t;

    // Memory to writeback bundle, before and after the latch.
    typedef struct packed {
        logic [`CORE_DATA_W-1:0]    pc;
        logic [`CORE_DATA_W-1:0]    instruction;
        logic [`CORE_DATA_W-1:0]    alu_out;
        logic [`CORE_DATA_W-1:0]    read_data;
        logic                       mem_to_reg;
        logic                       link;
        logic                       reg_write;
        logic                       halt;
        logic [`CORE_REG_SEL_W-1:0] write_sel;
        logic                       instr_align_err;
        logic                       data_align_err;
    } mem_wb_t;

    // Register file write port.
    typedef struct packed {
        logic                       en;
        logic [`CORE_REG_SEL_W-1:0] sel;
        logic [`CORE_DATA_W-1:0]    data;
    } reg_wr_t;

endpackage

//--- memory/memory_stage.sv
`include "core_defines.svh"

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_bundle
);

    localparam int addr_w = $clog2(`CORE_MEM_WORDS);

    logic [`CORE_DATA_W-1:0] data_mem [`CORE_MEM_WORDS];
    logic [addr_w-1:0]       word_addr;
    logic                    misaligned;
    logic                    store_en;

    // Word addressed, so the byte offset bit is dropped.
    assign word_addr = ex_mem.alu_out[addr_w:1];

    assign misaligned = (ex_mem.mem_read | ex_mem.mem_write) & ex_mem.alu_out[0];

    // Misaligned stores never reach the array.
    assign store_en = ex_mem.mem_write & ~misaligned & ~reset;

    always_ff @(posedge clk) begin
        if (store_en) begin
            data_mem[word_addr] <= ex_mem.store_data;
        end
    end

    always_comb begin
        mem_bundle.pc              = ex_mem.pc;
        mem_bundle.instruction     = ex_mem.instruction;
        mem_bundle.alu_out         = ex_mem.alu_out;
        mem_bundle.mem_to_reg      = ex_mem.mem_to_reg;
        mem_bundle.link            = ex_mem.link;
        mem_bundle.reg_write       = ex_mem.reg_write;
        mem_bundle.halt            = ex_mem.halt;
        mem_bundle.write_sel       = ex_mem.write_sel;
        mem_bundle.instr_align_err = ex_mem.instr_align_err;
        mem_bundle.data_align_err  = misaligned;
        // Async read, old contents on a same-cycle store.
        if (ex_mem.mem_read) begin
            mem_bundle.read_data = data_mem[word_addr];
        end else begin
            mem_bundle.read_data = '0;
        end
    end

endmodule

//--- design/mem_wb_latch.sv
`include "core_defines.svh"

module mem_wb_latch (
    input  logic              clk,
    input  logic              reset,
    input  logic              nop,
    input  pipe_pkg::mem_wb_t mem_bundle,
    output pipe_pkg::mem_wb_t wb_bundle
);

    import pipe_pkg::*;

    // Bubble contents, all flags low.
    localparam mem_wb_t nop_bundle = '{
        pc:          `CORE_NOP_FILL,
        instruction: `CORE_NOP_INSTR,
        alu_out:     `CORE_NOP_FILL,
        read_data:   `CORE_NOP_FILL,
        write_sel:   `CORE_NOP_SEL,
        default:     '0
    };

    mem_wb_t next_bundle;
    logic    kill_write;

    assign kill_write = mem_bundle.halt | mem_bundle.instr_align_err
                      | mem_bundle.data_align_err;

    always_comb begin
        next_bundle           = mem_bundle;
        next_bundle.reg_write = mem_bundle.reg_write & ~kill_write;
        if (nop) begin
            next_bundle = nop_bundle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_bundle <= '0;
        end else begin
            wb_bundle <= next_bundle;
        end
    end

endmodule

//--- writeback/writeback_stage.sv
`include "core_defines.svh"

module writeback_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_pkg::mem_wb_t     wb_bundle,
    output pipe_pkg::reg_wr_t     reg_wr,
    output isa_pkg::core_status_e status
);

    import isa_pkg::*;

    localparam logic [`CORE_DATA_W-1:0] link_step = 2;

    wb_src_e                 wb_src;
    core_status_e            status_next;
    logic [`CORE_DATA_W-1:0] write_data;
    logic                    any_err;

    // Link wins over a load.
    always_comb begin
        if (wb_bundle.link) begin
            wb_src = LINK;
        end else if (wb_bundle.mem_to_reg) begin
            wb_src = MEM;
        end else begin
            wb_src = ALU;
        end
    end

    always_comb begin
        case (wb_src)
            LINK:    write_data = wb_bundle.pc + link_step;
            MEM:     write_data = wb_bundle.read_data;
            default: write_data = wb_bundle.alu_out;
        endcase
    end

    assign any_err = wb_bundle.instr_align_err | wb_bundle.data_align_err;

    // Errors take precedence over halt.
    always_comb begin
        status_next = status;
        case (status)
            RUN: begin
                if (any_err) begin
                    status_next = FAULT;
                end else if (wb_bundle.halt) begin
                    status_next = HALTED;
                end
            end
            HALTED:  status_next = HALTED;
            FAULT:   status_next = FAULT;
            default: status_next = FAULT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= RUN;
        end else begin
            status <= status_next;
        end
    end

    // No writes once stopped.
    assign reg_wr.en   = wb_bundle.reg_write & (status == RUN);
    assign reg_wr.sel  = wb_bundle.write_sel;
    assign reg_wr.data = write_data;

endmodule

//--- design/reg_file.sv
`include "core_defines.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  pipe_pkg::reg_wr_t          reg_wr,
    input  logic [`CORE_REG_SEL_W-1:0] read_sel_a,
    input  logic [`CORE_REG_SEL_W-1:0] read_sel_b,
    output logic [`CORE_DATA_W-1:0]    read_data_a,
    output logic [`CORE_DATA_W-1:0]    read_data_b
);

    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.en) begin
            regs[reg_wr.sel] <= reg_wr.data;
        end
    end

    // Reads see the value before a same-edge write.
    assign read_data_a = regs[read_sel_a];
    assign read_data_b = regs[read_sel_b];

endmodule

//--- design/mem_wb_top.sv
`include "core_defines.svh"

module mem_wb_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       nop,
    input  pipe_pkg::ex_mem_t          ex_mem,
    input  logic [`CORE_REG_SEL_W-1:0] read_sel_a,
    input  logic [`CORE_REG_SEL_W-1:0] read_sel_b,
    output pipe_pkg::mem_wb_t          wb_bundle,
    output logic [`CORE_DATA_W-1:0]    read_data_a,
    output logic [`CORE_DATA_W-1:0]    read_data_b,
    output isa_pkg::core_status_e      status
);

    import pipe_pkg::*;

    mem_wb_t mem_bundle;
    reg_wr_t reg_wr;

    memory_stage memory_stage_i (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .mem_bundle (mem_bundle)
    );

    mem_wb_latch mem_wb_latch_i (
        .clk        (clk),
        .reset      (reset),
        .nop        (nop),
        .mem_bundle (mem_bundle),
        .wb_bundle  (wb_bundle)
    );

    writeback_stage writeback_stage_i (
        .clk       (clk),
        .reset     (reset),
        .wb_bundle (wb_bundle),
        .reg_wr    (reg_wr),
        .status    (status)
    );

    reg_file reg_file_i (
        .clk         (clk),
        .reset       (reset),
        .reg_wr      (reg_wr),
        .read_sel_a  (read_sel_a),
        .read_sel_b  (read_sel_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b)
    );

endmodule

//--- verif/mem_wb_assert.sv
`include "core_defines.svh"

module mem_wb_assert (
    input logic                       clk,
    input logic                       reset,
    input logic                       nop,
    input pipe_pkg::ex_mem_t          ex_mem,
    input logic [`CORE_REG_SEL_W-1:0] read_sel_a,
    input logic [`CORE_REG_SEL_W-1:0] read_sel_b,
    input pipe_pkg::mem_wb_t          wb_bundle,
    input logic [`CORE_DATA_W-1:0]    read_data_a,
    input logic [`CORE_DATA_W-1:0]    read_data_b,
    input isa_pkg::core_status_e      status
);

    import pipe_pkg::*;
    import isa_pkg::*;

    localparam int addr_w = $clog2(`CORE_MEM_WORDS);

    int value_errs = 0;
    int status_errs = 0;

    logic [`CORE_DATA_W-1:0]    shadow_regs [`CORE_REG_COUNT];
    logic [`CORE_DATA_W-1:0]    shadow_mem [`CORE_MEM_WORDS];
    logic [`CORE_MEM_WORDS-1:0] shadow_valid;
    logic [addr_w-1:0]          word_addr;
    logic                       misaligned;
    logic                       exp_write;
    logic [`CORE_DATA_W-1:0]    exp_read;
    logic [`CORE_DATA_W-1:0]    wb_value;
    logic [`CORE_DATA_W-1:0]    exp_a;
    logic [`CORE_DATA_W-1:0]    exp_b;
    mem_wb_t                    exp_now;
    mem_wb_t                    exp_q;
    logic                       known_now;
    logic                       known_q;
    logic                       live_q;
    core_status_e               exp_status;

    function automatic mem_wb_t without_data(input mem_wb_t b);
        mem_wb_t r;
        r = b;
        r.read_data = '0;
        return r;
    endfunction

    assign word_addr  = ex_mem.alu_out[addr_w:1];
    assign misaligned = (ex_mem.mem_read | ex_mem.mem_write) & ex_mem.alu_out[0];
    assign exp_write  = ex_mem.reg_write & ~ex_mem.halt & ~ex_mem.instr_align_err & ~misaligned;
    assign exp_read   = ex_mem.mem_read ? shadow_mem[word_addr] : '0;
    assign wb_value   = wb_bundle.link ? wb_bundle.pc + 16'd2
                      : wb_bundle.mem_to_reg ? wb_bundle.read_data : wb_bundle.alu_out;
    assign exp_a      = shadow_regs[read_sel_a];
    assign exp_b      = shadow_regs[read_sel_b];

    // Latch contents expected after this edge.
    always_comb begin
        exp_now = '{ex_mem.pc, ex_mem.instruction, ex_mem.alu_out, exp_read,
                    ex_mem.mem_to_reg, ex_mem.link, exp_write, ex_mem.halt,
                    ex_mem.write_sel, ex_mem.instr_align_err, misaligned};
        known_now = ~ex_mem.mem_read | shadow_valid[word_addr];
        if (nop) begin
            exp_now = '{pc: `CORE_NOP_FILL, instruction: `CORE_NOP_INSTR,
                        alu_out: `CORE_NOP_FILL, read_data: `CORE_NOP_FILL,
                        write_sel: `CORE_NOP_SEL, default: '0};
            known_now = 1'b1;
        end
    end

    always_comb begin
        exp_status = status;
        if (status == RUN) begin
            if (wb_bundle.instr_align_err || wb_bundle.data_align_err) begin
                exp_status = FAULT;
            end else if (wb_bundle.halt) begin
                exp_status = HALTED;
            end
        end
    end

    always_ff @(posedge clk) begin
        exp_q   <= exp_now;
        known_q <= known_now;
        live_q  <= ~reset;
        if (reset) begin
            shadow_valid <= '0;
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                shadow_regs[i] <= '0;
            end
        end else begin
            if (ex_mem.mem_write && !misaligned) begin
                shadow_mem[word_addr]   <= ex_mem.store_data;
                shadow_valid[word_addr] <= 1'b1;
            end
            if (wb_bundle.reg_write && status == RUN) begin
                shadow_regs[wb_bundle.write_sel] <= wb_value;
            end
        end
    end

    a_latch: assert property (@(posedge clk)
        live_q |-> without_data(wb_bundle) == without_data(exp_q))
        else begin
            value_errs++;
            $error("ERR wb_bundle got %h exp %h", $sampled(wb_bundle), $sampled(exp_q));
        end

    // Loads only checked once the word has a known store.
    a_load: assert property (@(posedge clk)
        live_q && known_q |-> wb_bundle.read_data == exp_q.read_data)
        else begin
            value_errs++;
            $error("ERR wb_bundle.read_data got %h exp %h",
                   $sampled(wb_bundle.read_data), $sampled(exp_q.read_data));
        end

    a_regs: assert property (@(posedge clk)
        !reset |-> read_data_a == exp_a && read_data_b == exp_b)
        else begin
            value_errs++;
            $error("ERR read_data_a/read_data_b got %h/%h exp %h/%h", $sampled(read_data_a),
                   $sampled(read_data_b), $sampled(exp_a), $sampled(exp_b));
        end

    a_status: assert property (@(posedge clk)
        !reset |=> status == $past(exp_status))
        else begin
            status_errs++;
            $error("status took a wrong step between RUN, HALTED and FAULT");
        end

    a_reset: assert property (@(posedge clk)
        reset |=> wb_bundle == '0 && status == RUN)
        else begin
            status_errs++;
            $error("wb_bundle or status was not cleared by reset");
        end

endmodule

bind mem_wb_top mem_wb_assert mem_wb_assert_i (.*);

//--- verif/mem_wb_tb.sv
`include "core_defines.svh"

module mem_wb_tb;

    import pipe_pkg::*;
    import isa_pkg::*;

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 3;
    localparam int mem_ops         = 8;
    localparam int rand_ops        = 16;
    localparam int nop_ops         = 12;
    localparam int stop_ops        = 6;
    localparam int readback_cycles = `CORE_REG_COUNT + 2;
    localparam int stim_cycles     = 2 * (reset_cycles + 1) + 2 * mem_ops + rand_ops
                                   + nop_ops + 2 * (stop_ops + 2) + 7 * readback_cycles + 4;

    logic                       clk;
    logic                       reset;
    logic                       nop;
    ex_mem_t                    ex_mem;
    logic [`CORE_REG_SEL_W-1:0] read_sel_a;
    logic [`CORE_REG_SEL_W-1:0] read_sel_b;
    mem_wb_t                    wb_bundle;
    logic [`CORE_DATA_W-1:0]    read_data_a;
    logic [`CORE_DATA_W-1:0]    read_data_b;
    core_status_e               status;
    logic [31:0]                rng;

    mem_wb_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Twice the planned stimulus length.
    initial begin
        #(clk_period * stim_cycles * 2);
        $display("Watchdog timeout, the stimulus did not finish in time.");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic issue(input ex_mem_t op, input logic bubble);
        @(posedge clk);
        ex_mem <= op;
        nop    <= bubble;
    endtask

    // ALU result or link write to a random register.
    task automatic random_write(output ex_mem_t op);
        op = '0;
        rng = xorshift(rng);
        op.pc = {rng[31:17], 1'b0};
        op.alu_out = rng[15:0];
        rng = xorshift(rng);
        op.write_sel = rng[3:0];
        op.link = rng[4];
        // Link must win over a load select.
        op.mem_to_reg = rng[4] & rng[5];
        op.reg_write = 1'b1;
        op.instruction = {rng[4] ? JAL : 5'b00010, rng[15:5]};
    endtask

    task automatic stop_writes();
        ex_mem_t op;
        for (int i = 0; i < stop_ops; i++) begin
            random_write(op);
            issue(op, 1'b0);
        end
    endtask

    task automatic read_back();
        for (int i = 0; i < readback_cycles; i++) begin
            @(posedge clk);
            ex_mem     <= '0;
            nop        <= 1'b0;
            read_sel_a <= 4'(i);
            read_sel_b <= 4'(`CORE_REG_COUNT - 1 - i);
        end
    endtask

    task automatic store_then_load();
        logic [`CORE_DATA_W-1:0] addr [mem_ops];
        ex_mem_t                 op;
        for (int i = 0; i < mem_ops; i++) begin
            rng = xorshift(rng);
            addr[i] = {7'd0, rng[7:0], 1'b0};
            op = '0;
            op.instruction = {ST, 11'd0};
            op.alu_out = addr[i];
            op.store_data = rng[31:16];
            op.mem_write = 1'b1;
            issue(op, 1'b0);
        end
        for (int i = 0; i < mem_ops; i++) begin
            op = '0;
            op.instruction = {LD, 11'd0};
            op.alu_out = addr[i];
            op.mem_read = 1'b1;
            op.mem_to_reg = 1'b1;
            op.reg_write = 1'b1;
            op.write_sel = 4'(i);
            issue(op, 1'b0);
        end
    endtask

    initial begin
        ex_mem_t op;
        int      total_errs;
        reset = 1'b1;
        nop = 1'b0;
        ex_mem = '0;
        read_sel_a = '0;
        read_sel_b = '0;
        rng = 32'hc893;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        read_back();
        store_then_load();
        read_back();
        for (int i = 0; i < rand_ops; i++) begin
            random_write(op);
            issue(op, 1'b0);
        end
        read_back();
        // Every third cycle is a bubble.
        for (int i = 0; i < nop_ops; i++) begin
            random_write(op);
            issue(op, 1'(i % 3 == 1));
        end
        read_back();
        // Odd store between a store and a load of the same word.
        rng = xorshift(rng);
        op = '0;
        op.instruction = {ST, 11'd0};
        op.alu_out = {rng[15:1], 1'b0};
        op.store_data = rng[31:16];
        op.mem_write = 1'b1;
        issue(op, 1'b0);
        op.alu_out[0] = 1'b1;
        op.store_data = ~rng[31:16];
        op.reg_write = 1'b1;
        issue(op, 1'b0);
        op = '0;
        op.instruction = {LD, 11'd0};
        op.alu_out = {rng[15:1], 1'b0};
        op.mem_read = 1'b1;
        op.mem_to_reg = 1'b1;
        op.reg_write = 1'b1;
        issue(op, 1'b0);
        // Writes that the fault must drop.
        stop_writes();
        read_back();
        @(posedge clk);
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        read_back();
        op = '0;
        op.instruction = {HALT, 11'd0};
        op.halt = 1'b1;
        op.reg_write = 1'b1;
        issue(op, 1'b0);
        stop_writes();
        read_back();
        repeat (4) @(posedge clk);
        total_errs = dut_i.mem_wb_assert_i.value_errs + dut_i.mem_wb_assert_i.status_errs;
        $display("Errors: %0d value, %0d status", dut_i.mem_wb_assert_i.value_errs,
                 dut_i.mem_wb_assert_i.status_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
memory/memory_stage.sv
design/mem_wb_latch.sv
writeback/writeback_stage.sv
design/reg_file.sv
design/mem_wb_top.sv
verif/mem_wb_assert.sv
verif/mem_wb_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_wb_tb -f src.f -o mem_wb_sim
./obj_dir/mem_wb_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi
